/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [core_pkg::OP_SIZE - 1 : 0] op,
    input  logic [core_pkg::REG_SIZE - 1 : 0] a,
    input  logic [core_pkg::REG_SIZE - 1 : 0] b,
    output logic [core_pkg::REG_SIZE - 1 : 0] result
);

    logic [2 : 0] shamt;

    assign shamt = b[2 : 0];   // shifts use the low three bits only

    always_comb
    begin
        case (op)
            core_pkg::OP_ADD:
                result = a + b;
            core_pkg::OP_SUB:
                result = a - b;
            core_pkg::OP_AND:
                result = a & b;
            core_pkg::OP_OR:
                result = a | b;
            core_pkg::OP_XOR:
                result = a ^ b;
            core_pkg::OP_LSHIFT:
                result = a << shamt;
            core_pkg::OP_RSHIFT:
                result = a >> shamt;
            core_pkg::OP_CMPGE:
                result = (a >= b) ? core_pkg::REG_SIZE'(1) : '0;   // unsigned
            default:
                result = '0;
        endcase
    end

endmodule

/* hw/core.sv */
`timescale 1ns/1ns

module core (
    input  logic clk,
    input  logic reset,
    input  logic init_r0_flag,
    input  logic [core_pkg::REG_SIZE - 1 : 0] init_r0_data,
    input  logic [core_pkg::INSN_COUNT * core_pkg::INSN_SIZE - 1 : 0] insn_data,
    input  logic start,
    output logic ready,
    input  logic [core_pkg::REG_SIZE - 1 : 0] rd_data,
    input  logic ready_sig,
    output logic [core_pkg::REG_SIZE - 1 : 0] wr_data,
    output logic [core_pkg::ADDR_SIZE - 1 : 0] addr,
    output logic [1 : 0] enable
);

    localparam int IW = core_pkg::INSN_SIZE;
    localparam int RW = core_pkg::REG_SIZE;
    localparam int PW = core_pkg::REG_PTR_SIZE;
    localparam logic [IW - 1 : 0] NOP_INSN = {core_pkg::OP_NOP, {(IW - core_pkg::OP_SIZE){1'b0}}};

    typedef enum logic [1 : 0] {MS_IDLE, MS_REQ, MS_DROP} mem_state_t;

    function automatic logic [core_pkg::OP_SIZE - 1 : 0] op_of(input logic [IW - 1 : 0] insn);
        return insn[IW - 1 -: core_pkg::OP_SIZE];
    endfunction

    function automatic logic is_f1(input logic [core_pkg::OP_SIZE - 1 : 0] op);
        return op inside {core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_OR,
                          core_pkg::OP_XOR, core_pkg::OP_LSHIFT, core_pkg::OP_RSHIFT,
                          core_pkg::OP_CMPGE};
    endfunction

    function automatic logic writes_reg(input logic [IW - 1 : 0] insn);
        logic [core_pkg::OP_SIZE - 1 : 0] op;
        op = op_of(insn);
        return is_f1(op) || op == core_pkg::OP_LD || op == core_pkg::OP_SET_CONST;
    endfunction

    function automatic logic [PW - 1 : 0] dst_of(input logic [IW - 1 : 0] insn);
        if (op_of(insn) == core_pkg::OP_SET_CONST)
            return insn[core_pkg::SRC0_OFFSET +: PW];   // SET_CONST writes src0
        return insn[core_pkg::DST_OFFSET +: PW];
    endfunction

    // does later stage insn 'other' write a register that 'insn' reads
    function automatic logic raw_hit(input logic [IW - 1 : 0] insn, input logic [IW - 1 : 0] other);
        logic [core_pkg::OP_SIZE - 1 : 0] op;
        logic uses0;
        logic uses1;
        op    = op_of(insn);
        uses0 = is_f1(op) || op == core_pkg::OP_LD || op == core_pkg::OP_ST;
        uses1 = is_f1(op) || op == core_pkg::OP_ST;
        return writes_reg(other) &&
               ((uses0 && insn[core_pkg::SRC0_OFFSET +: PW] == dst_of(other)) ||
                (uses1 && insn[core_pkg::SRC1_OFFSET +: PW] == dst_of(other)));
    endfunction

    logic [IW - 1 : 0] fd_insn, dx_insn, xm_insn, mw_insn;
    logic [RW - 1 : 0] dx_a, dx_b, xm_a, xm_b, xm_val, mw_val;
    logic [RW - 1 : 0] rf_data0, rf_data1, alu_result, mem_rd_q;
    logic [core_pkg::OP_SIZE - 1 : 0] xm_op;
    mem_state_t ms_state;
    logic hazard, xm_mem, mem_hold, retire;

    assign hazard   = raw_hit(fd_insn, dx_insn) || raw_hit(fd_insn, xm_insn) ||
                      raw_hit(fd_insn, mw_insn);
    assign xm_op    = op_of(xm_insn);
    assign xm_mem   = xm_op == core_pkg::OP_LD || xm_op == core_pkg::OP_ST;
    assign mem_hold = xm_mem && !(ms_state == MS_DROP && !ready_sig);
    assign retire   = op_of(mw_insn) == core_pkg::OP_READY;

    insn_fetch insn_fetch_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .insn_data (insn_data),
        .stall     (hazard | mem_hold),
        .retire    (retire),
        .ready     (ready),
        .fd_insn   (fd_insn)
    );

    reg_file reg_file_i (
        .clk          (clk),
        .reset        (reset),
        .rd_ptr0      (fd_insn[core_pkg::SRC0_OFFSET +: PW]),
        .rd_ptr1      (fd_insn[core_pkg::SRC1_OFFSET +: PW]),
        .rd_data0     (rf_data0),
        .rd_data1     (rf_data1),
        .wr_en        (writes_reg(mw_insn)),
        .wr_ptr       (dst_of(mw_insn)),
        .wr_data      (mw_val),
        .init_r0      (start & ready & init_r0_flag),
        .init_r0_data (init_r0_data)
    );

    alu alu_i (
        .op     (op_of(dx_insn)),
        .a      (dx_a),
        .b      (dx_b),
        .result (alu_result)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dx_insn <= NOP_INSN;
            xm_insn <= NOP_INSN;
            mw_insn <= NOP_INSN;
        end
        else
        begin
            if (!mem_hold)
            begin
                dx_insn <= hazard ? NOP_INSN : fd_insn;   // bubble on interlock
                xm_insn <= dx_insn;
            end
            mw_insn <= mem_hold ? NOP_INSN : xm_insn;
        end
    end

    // operand and result payload
    always_ff @(posedge clk)
    begin
        if (!mem_hold)
        begin
            dx_a   <= rf_data0;
            dx_b   <= rf_data1;
            xm_a   <= dx_a;
            xm_b   <= dx_b;
            xm_val <= (op_of(dx_insn) == core_pkg::OP_SET_CONST) ?
                      dx_insn[core_pkg::CONST_OFFSET +: RW] : alu_result;
        end
        mw_val <= (xm_op == core_pkg::OP_LD) ? mem_rd_q : xm_val;
    end

    // four-phase master
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ms_state <= MS_IDLE;
            enable   <= core_pkg::EN_IDLE;
        end
        else
        begin
            case (ms_state)
                MS_IDLE:
                    if (xm_mem)
                    begin
                        enable   <= (xm_op == core_pkg::OP_ST) ? core_pkg::EN_WRITE :
                                                                 core_pkg::EN_READ;
                        ms_state <= MS_REQ;
                    end
                MS_REQ:
                    if (ready_sig)
                    begin
                        enable   <= core_pkg::EN_IDLE;
                        ms_state <= MS_DROP;
                    end
                MS_DROP:
                    if (!ready_sig)
                        ms_state <= MS_IDLE;   // ack gone, next request allowed
                default:
                    ms_state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ms_state == MS_REQ && ready_sig)
            mem_rd_q <= rd_data;
    end

    assign addr    = xm_a;   // held steady by the stall
    assign wr_data = xm_b;

endmodule

/* hw/core_pkg.sv */
package core_pkg;

    localparam int INSN_SIZE     = 16;
    localparam int INSN_COUNT    = 16;
    localparam int INSN_PTR_SIZE = 4;
    localparam int REG_SIZE      = 8;
    localparam int REG_COUNT     = 16;
    localparam int REG_PTR_SIZE  = 4;
    localparam int ADDR_SIZE     = 8;
    localparam int OP_SIZE       = 4;

    // opcodes, top nibble of the instruction
    localparam logic [OP_SIZE - 1 : 0] OP_NOP       = 4'd0;
    localparam logic [OP_SIZE - 1 : 0] OP_READY     = 4'd1;
    localparam logic [OP_SIZE - 1 : 0] OP_ADD       = 4'd2;
    localparam logic [OP_SIZE - 1 : 0] OP_SUB       = 4'd3;
    localparam logic [OP_SIZE - 1 : 0] OP_AND       = 4'd4;
    localparam logic [OP_SIZE - 1 : 0] OP_OR        = 4'd5;
    localparam logic [OP_SIZE - 1 : 0] OP_XOR       = 4'd6;
    localparam logic [OP_SIZE - 1 : 0] OP_LSHIFT    = 4'd7;
    localparam logic [OP_SIZE - 1 : 0] OP_RSHIFT    = 4'd8;
    localparam logic [OP_SIZE - 1 : 0] OP_CMPGE     = 4'd9;
    localparam logic [OP_SIZE - 1 : 0] OP_SET_CONST = 4'd10;
    localparam logic [OP_SIZE - 1 : 0] OP_LD        = 4'd11;
    localparam logic [OP_SIZE - 1 : 0] OP_ST        = 4'd12;

    // field offsets: op 15..12, src0 11..8, src1 7..4, dst 3..0
    localparam int SRC0_OFFSET  = 8;
    localparam int SRC1_OFFSET  = 4;
    localparam int DST_OFFSET   = 0;
    localparam int CONST_OFFSET = 0;

    // memory port enable codes
    localparam logic [1 : 0] EN_IDLE  = 2'd0;
    localparam logic [1 : 0] EN_READ  = 2'd1;
    localparam logic [1 : 0] EN_WRITE = 2'd2;

endpackage

/* hw/core_top.sv */
`timescale 1ns/1ns

module core_top #(
    parameter int MEM_LATENCY = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic init_r0_flag,
    input  logic [core_pkg::REG_SIZE - 1 : 0] init_r0_data,
    input  logic [core_pkg::INSN_COUNT * core_pkg::INSN_SIZE - 1 : 0] insn_data,
    input  logic start,
    output logic ready,
    input  logic [core_pkg::ADDR_SIZE - 1 : 0] host_addr,
    output logic [core_pkg::REG_SIZE - 1 : 0] host_rd_data
);

    logic [core_pkg::ADDR_SIZE - 1 : 0] addr;
    logic [core_pkg::REG_SIZE - 1 : 0] wr_data;
    logic [core_pkg::REG_SIZE - 1 : 0] rd_data;
    logic [1 : 0] enable;
    logic ready_sig;

    core core_i (
        .clk          (clk),
        .reset        (reset),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .start        (start),
        .ready        (ready),
        .rd_data      (rd_data),
        .ready_sig    (ready_sig),
        .wr_data      (wr_data),
        .addr         (addr),
        .enable       (enable)
    );

    data_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) data_mem_i (
        .clk          (clk),
        .reset        (reset),
        .addr         (addr),
        .wr_data      (wr_data),
        .enable       (enable),
        .rd_data      (rd_data),
        .ready_sig    (ready_sig),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

endmodule

/* hw/data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_LATENCY = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic [core_pkg::ADDR_SIZE - 1 : 0] addr,
    input  logic [core_pkg::REG_SIZE - 1 : 0] wr_data,
    input  logic [1 : 0] enable,
    output logic [core_pkg::REG_SIZE - 1 : 0] rd_data,
    output logic ready_sig,
    input  logic [core_pkg::ADDR_SIZE - 1 : 0] host_addr,
    output logic [core_pkg::REG_SIZE - 1 : 0] host_rd_data
);

    localparam int DEPTH = 1 << core_pkg::ADDR_SIZE;
    localparam int CNT_W = $clog2(MEM_LATENCY + 2);

    logic [core_pkg::REG_SIZE - 1 : 0] mem [DEPTH];
    logic [CNT_W - 1 : 0] cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
            cnt       <= '0;
            ready_sig <= 1'b0;
        end
        else if (enable != core_pkg::EN_IDLE && !ready_sig)
        begin
            if (cnt == CNT_W'(MEM_LATENCY))
            begin
                if (enable == core_pkg::EN_WRITE)
                    mem[addr] <= wr_data;
                rd_data   <= mem[addr];
                ready_sig <= 1'b1;
                cnt       <= '0;
            end
            else
                cnt <= cnt + 1'b1;
        end
        else if (enable == core_pkg::EN_IDLE && ready_sig)
            ready_sig <= 1'b0;   // request withdrawn
    end

    assign host_rd_data = mem[host_addr];

endmodule

/* hw/insn_fetch.sv */
`timescale 1ns/1ns

module insn_fetch (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [core_pkg::INSN_COUNT * core_pkg::INSN_SIZE - 1 : 0] insn_data,
    input  logic stall,
    input  logic retire,
    output logic ready,
    output logic [core_pkg::INSN_SIZE - 1 : 0] fd_insn
);

    localparam logic [core_pkg::INSN_SIZE - 1 : 0] NOP_INSN =
        {core_pkg::OP_NOP, {(core_pkg::INSN_SIZE - core_pkg::OP_SIZE){1'b0}}};
    localparam logic [core_pkg::INSN_SIZE - 1 : 0] READY_INSN =
        {core_pkg::OP_READY, {(core_pkg::INSN_SIZE - core_pkg::OP_SIZE){1'b0}}};
    localparam logic [core_pkg::INSN_PTR_SIZE - 1 : 0] LAST_SLOT =
        core_pkg::INSN_PTR_SIZE'(core_pkg::INSN_COUNT - 1);

    logic [core_pkg::INSN_SIZE - 1 : 0] insn_mem [core_pkg::INSN_COUNT];
    logic [core_pkg::INSN_PTR_SIZE - 1 : 0] insn_ptr;
    logic tail;    // last slot issued, READY comes next
    logic block;   // nothing left to fetch
    logic load;

    assign load = start & ready;

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            for (int i = 0; i < core_pkg::INSN_COUNT; i++)
                insn_mem[i] <= insn_data[i * core_pkg::INSN_SIZE +: core_pkg::INSN_SIZE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            insn_ptr <= '0;
            tail     <= 1'b0;
            block    <= 1'b1;
            ready    <= 1'b1;
            fd_insn  <= NOP_INSN;
        end
        else if (load)
        begin
            insn_ptr <= '0;
            tail     <= 1'b0;
            block    <= 1'b0;
            ready    <= 1'b0;
            fd_insn  <= NOP_INSN;
        end
        else
        begin
            if (retire)
                ready <= 1'b1;
            if (!stall)
            begin
                if (block)
                    fd_insn <= NOP_INSN;
                else if (tail)
                begin
                    fd_insn <= READY_INSN;   // end of program marker
                    block   <= 1'b1;
                end
                else
                begin
                    fd_insn  <= insn_mem[insn_ptr];
                    insn_ptr <= insn_ptr + 1'b1;
                    if (insn_ptr == LAST_SLOT)
                        tail <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic clk,
    input  logic reset,
    input  logic [core_pkg::REG_PTR_SIZE - 1 : 0] rd_ptr0,
    input  logic [core_pkg::REG_PTR_SIZE - 1 : 0] rd_ptr1,
    output logic [core_pkg::REG_SIZE - 1 : 0] rd_data0,
    output logic [core_pkg::REG_SIZE - 1 : 0] rd_data1,
    input  logic wr_en,
    input  logic [core_pkg::REG_PTR_SIZE - 1 : 0] wr_ptr,
    input  logic [core_pkg::REG_SIZE - 1 : 0] wr_data,
    input  logic init_r0,
    input  logic [core_pkg::REG_SIZE - 1 : 0] init_r0_data
);

    logic [core_pkg::REG_SIZE - 1 : 0] regs [core_pkg::REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < core_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (init_r0)
            regs[0] <= init_r0_data;   // only while the core is idle
        else if (wr_en)
            regs[wr_ptr] <= wr_data;
    end

    // same-cycle write shows through to the readers
    assign rd_data0 = (wr_en && wr_ptr == rd_ptr0) ? wr_data : regs[rd_ptr0];
    assign rd_data1 = (wr_en && wr_ptr == rd_ptr1) ? wr_data : regs[rd_ptr1];

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* sim/core_tb.sv */
`timescale 1ns/1ns

module core_tb;

    localparam int MEM_LATENCY = 2;
    localparam int INSN_BITS = core_pkg::INSN_COUNT * core_pkg::INSN_SIZE;
    localparam string GOLDEN_FILE = "sim/golden_programs.txt";

    logic clk = 1'b0;
    logic reset;
    logic init_r0_flag;
    logic [core_pkg::REG_SIZE - 1 : 0] init_r0_data;
    logic [INSN_BITS - 1 : 0] insn_data;
    logic start;
    logic ready;
    logic [core_pkg::ADDR_SIZE - 1 : 0] host_addr;
    logic [core_pkg::REG_SIZE - 1 : 0] host_rd_data;

    // one entry per program record
    logic rec_flag [$];
    logic [core_pkg::REG_SIZE - 1 : 0] rec_r0 [$];
    logic [INSN_BITS - 1 : 0] rec_insn [$];
    int rec_pairs [$];
    // expected memory contents, all records back to back
    logic [core_pkg::ADDR_SIZE - 1 : 0] exp_addr [$];
    logic [core_pkg::REG_SIZE - 1 : 0] exp_val [$];

    int errors = 0;
    int checks = 0;
    int watchdog_cycles = 0;

    core_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) core_top_i (
        .clk          (clk),
        .reset        (reset),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .start        (start),
        .ready        (ready),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

    always #10 clk = ~clk;

    task automatic load_records(output bit ok);
        int fd;
        int n;
        int flag;
        int r0;
        int count;
        int word;
        int a;
        int v;
        logic [INSN_BITS - 1 : 0] insn;
        ok = 1'b1;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            ok = 1'b0;
            return;
        end
        n = $fscanf(fd, "%h %h %d", flag, r0, count);
        while (n == 3 && ok)
        begin
            insn = '0;
            for (int i = 0; i < core_pkg::INSN_COUNT; i++)
            begin
                if ($fscanf(fd, "%h", word) != 1)
                    ok = 1'b0;
                insn[i * core_pkg::INSN_SIZE +: core_pkg::INSN_SIZE] =
                    word[core_pkg::INSN_SIZE - 1 : 0];   // slot 0 in the low bits
            end
            for (int p = 0; p < count; p++)
            begin
                if ($fscanf(fd, "%h %h", a, v) != 2)
                    ok = 1'b0;
                exp_addr.push_back(a[core_pkg::ADDR_SIZE - 1 : 0]);
                exp_val.push_back(v[core_pkg::REG_SIZE - 1 : 0]);
            end
            rec_flag.push_back(flag[0]);
            rec_r0.push_back(r0[core_pkg::REG_SIZE - 1 : 0]);
            rec_insn.push_back(insn);
            rec_pairs.push_back(count);
            n = $fscanf(fd, "%h %h %d", flag, r0, count);
        end
        $fclose(fd);
        if (rec_flag.size() == 0)
            ok = 1'b0;
    endtask

    task automatic wait_ready();
        while (ready !== 1'b1)
            @(negedge clk);
    endtask

    task automatic check_mem(input logic [core_pkg::ADDR_SIZE - 1 : 0] a,
                             input logic [core_pkg::REG_SIZE - 1 : 0] expected);
        @(posedge clk);
        host_addr <= a;
        @(negedge clk);
        checks++;
        assert (host_rd_data == expected)
        else
        begin
            errors++;
            $display("ERROR: %0t ns: mem[%02h] expected %02h, read %02h",
                     $time, a, expected, host_rd_data);
        end
    endtask

    task automatic run_program(input int r);
        wait_ready();
        @(posedge clk);
        insn_data    <= rec_insn[r];
        init_r0_flag <= rec_flag[r];
        init_r0_data <= rec_r0[r];
        start        <= 1'b1;
        @(posedge clk);
        start        <= 1'b0;
        init_r0_flag <= 1'b0;
        @(negedge clk);
        checks++;
        assert (ready == 1'b0)
        else
        begin
            errors++;
            $display("ERROR: %0t ns: ready still high after start of program %0d", $time, r);
        end
        wait_ready();   // READY has left writeback
    endtask

    initial
    begin
        bit ok;
        int base;
        reset        = 1'b1;
        start        = 1'b0;
        init_r0_flag = 1'b0;
        init_r0_data = '0;
        insn_data    = '0;
        host_addr    = '0;
        load_records(ok);
        if (!ok)
        begin
            errors++;
            $display("golden file %s is missing or malformed", GOLDEN_FILE);
        end
        else
        begin
            watchdog_cycles = rec_flag.size() * core_pkg::INSN_COUNT * (MEM_LATENCY + 8) + 200;
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            checks++;
            assert (ready == 1'b1)
            else
            begin
                errors++;
                $display("ERROR: %0t ns: ready low after reset", $time);
            end
            // memory comes out of reset cleared
            for (int i = 0; i < exp_addr.size(); i++)
                check_mem(exp_addr[i], '0);
            base = 0;
            for (int r = 0; r < rec_flag.size(); r++)
            begin
                run_program(r);
                for (int p = 0; p < rec_pairs[r]; p++)
                    check_mem(exp_addr[base + p], exp_val[base + p]);
                base += rec_pairs[r];
            end
        end
        $display("programs: %0d, checks: %0d, errors: %0d", rec_flag.size(), checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* sim/golden_programs.txt */
0 00 6
a15c a235 2123 3124 4125 5126 6127 7128
8129 912a c340 c560 c780 c9a0 c020 c210
91 27  14 7d  69 80
02 01  00 35  35 5c
1 0b 6
a103 2012 7213 3304 6425 8516 5637 9748
2879 495a c1a0 c000 c230 c450 c670 c890
03 6a  0b 0b  0e 70
65 6b  0d 7d  01 7e
0 00 6
a140 a29c c120 b103 2334 a541 c540 b006
3367 a814 c870 b809 696a ab42 cba0 0000
40 9c  41 38  14 91
42 9a  91 27  03 6a
1 e7 7
a100 c100 a207 9203 9024 7025 8026 2567
3348 a950 c970 c800 b10a 6a7b c2b0 0000
00 e7  50 81  ff e7  07 66
14 91  0d 7d  69 80

/* vlog.f */
hw/core_pkg.sv
hw/insn_fetch.sv
hw/reg_file.sv
hw/alu.sv
hw/core.sv
hw/data_mem.sv
hw/core_top.sv
sim/core_tb.sv
